// ==== hw/ntm_sinh_pkg.sv ====
package ntm_sinh_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Q8.8 input element
  localparam int ELEM_W    = 16;
  // Result and modulus
  localparam int RES_W     = 32;
  localparam int IDX_W     = 4;
  // Vector length 1 to 16 needs one more bit than the index
  localparam int SIZE_W    = 5;
  localparam int MAX_ELEMS = 16;
  localparam int FRAC_BITS = 8;

  // APB bus
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [RES_W-1:0]  res_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [SIZE_W-1:0] size_t;

  // Taylor denominators, 3! and 5!
  localparam res_t DIV_P3 = 32'd6;
  localparam res_t DIV_P5 = 32'd120;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL     = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS   = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_SIZE     = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_MODULO   = 8'h0C;
  // Element windows, one word per entry
  localparam logic [APB_ADDR_W-1:0] ADDR_IN_BASE  = 8'h40;
  localparam logic [APB_ADDR_W-1:0] ADDR_OUT_BASE = 8'h80;

  // Bit positions
  localparam int CTRL_START_BIT  = 0;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  //////////////////////////////
  // Bus and state types
  //////////////////////////////

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Vector controller
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    WAIT_SCALAR,
    FINISH
  } vec_state_e;

  // Scalar unit, one product per state
  typedef enum logic [2:0] {
    S_IDLE,
    S_SQ,
    S_CUBE,
    S_FIFTH,
    S_SUM
  } sinh_state_e;

endpackage

// ==== hw/ntm_apb_regs.sv ====
`timescale 1ns/1ps

module ntm_apb_regs (
  input  logic                   CLK,
  input  logic                   RST,
  input  ntm_sinh_pkg::apb_req_t apb_req,
  output ntm_sinh_pkg::apb_rsp_t apb_rsp,
  input  logic                   busy,
  input  logic                   done_set,
  input  ntm_sinh_pkg::idx_t     index,
  input  logic                   res_we,
  input  ntm_sinh_pkg::res_t     result,
  output logic                   start_pulse,
  output ntm_sinh_pkg::size_t    size,
  output ntm_sinh_pkg::res_t     modulo,
  output ntm_sinh_pkg::elem_t    elem
);

  // Configuration and sticky status
  ntm_sinh_pkg::size_t size_q;
  ntm_sinh_pkg::res_t  modulo_q;
  logic                done_q;

  // Element buffers
  ntm_sinh_pkg::elem_t in_buf  [ntm_sinh_pkg::MAX_ELEMS];
  ntm_sinh_pkg::res_t  out_buf [ntm_sinh_pkg::MAX_ELEMS];

  // Decoded access
  logic               wr;
  logic               is_ctrl;
  logic               is_status;
  logic               is_size;
  logic               is_mod;
  logic               is_in;
  logic               is_out;
  logic               bad_size;
  logic               wr_err;
  logic               wr_ok;
  ntm_sinh_pkg::idx_t a_idx;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  // Access phase of a write
  assign wr = apb_req.psel & apb_req.penable & apb_req.pwrite;

  assign is_ctrl   = (apb_req.paddr == ntm_sinh_pkg::ADDR_CTRL);
  assign is_status = (apb_req.paddr == ntm_sinh_pkg::ADDR_STATUS);
  assign is_size   = (apb_req.paddr == ntm_sinh_pkg::ADDR_SIZE);
  assign is_mod    = (apb_req.paddr == ntm_sinh_pkg::ADDR_MODULO);

  // Windows matched on the bits above the word index
  assign is_in  = (apb_req.paddr[ntm_sinh_pkg::APB_ADDR_W-1:ntm_sinh_pkg::IDX_W+2] ==
                   ntm_sinh_pkg::ADDR_IN_BASE[ntm_sinh_pkg::APB_ADDR_W-1:ntm_sinh_pkg::IDX_W+2]);
  assign is_out = (apb_req.paddr[ntm_sinh_pkg::APB_ADDR_W-1:ntm_sinh_pkg::IDX_W+2] ==
                   ntm_sinh_pkg::ADDR_OUT_BASE[ntm_sinh_pkg::APB_ADDR_W-1:ntm_sinh_pkg::IDX_W+2]);

  // Word index inside a window
  assign a_idx = apb_req.paddr[ntm_sinh_pkg::IDX_W+1:2];

  // Length must be 1 to MAX_ELEMS
  assign bad_size = is_size && ((apb_req.pwdata == '0) ||
                                (apb_req.pwdata > ntm_sinh_pkg::MAX_ELEMS));

  // Config writes locked out during a run
  assign wr_err = wr && ((busy && (is_ctrl || is_size || is_mod || is_in)) || bad_size);
  assign wr_ok  = wr && !wr_err;

  assign start_pulse = wr_ok && is_ctrl && apb_req.pwdata[ntm_sinh_pkg::CTRL_START_BIT];

  //////////////////////////////
  // Registers and buffers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_q   <= '0;
      modulo_q <= '0;
      done_q   <= 1'b0;
      for (int i = 0; i < ntm_sinh_pkg::MAX_ELEMS; i++) begin
        in_buf[i]  <= '0;
        out_buf[i] <= '0;
      end
    end else begin
      if (wr_ok && is_size) begin
        size_q <= apb_req.pwdata[ntm_sinh_pkg::SIZE_W-1:0];
      end
      if (wr_ok && is_mod) begin
        modulo_q <= apb_req.pwdata;
      end
      if (wr_ok && is_in) begin
        in_buf[a_idx] <= apb_req.pwdata[ntm_sinh_pkg::ELEM_W-1:0];
      end
      // Result write-back from the vector controller
      if (res_we) begin
        out_buf[index] <= result;
      end
      // Done stays up until the next start
      if (start_pulse) begin
        done_q <= 1'b0;
      end else if (done_set) begin
        done_q <= 1'b1;
      end
    end
  end

  // Read mux, out window is read only
  always_comb begin
    apb_rsp.prdata = '0;
    // No wait states
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = wr_err;
    if (is_status) begin
      apb_rsp.prdata[ntm_sinh_pkg::STATUS_BUSY_BIT] = busy;
      apb_rsp.prdata[ntm_sinh_pkg::STATUS_DONE_BIT] = done_q;
    end else if (is_size) begin
      apb_rsp.prdata = ntm_sinh_pkg::res_t'(size_q);
    end else if (is_mod) begin
      apb_rsp.prdata = modulo_q;
    end else if (is_in) begin
      apb_rsp.prdata = ntm_sinh_pkg::res_t'(in_buf[a_idx]);
    end else if (is_out) begin
      apb_rsp.prdata = out_buf[a_idx];
    end
  end

  assign size   = size_q;
  assign modulo = modulo_q;
  // Current element for the scalar unit
  assign elem   = in_buf[index];

  // Write-back only happens inside a run
  a_res_we_busy : assert property (@(posedge CLK) disable iff (RST) res_we |-> busy);

endmodule

// ==== hw/ntm_vector_sinh_fsm.sv ====
`timescale 1ns/1ps

module ntm_vector_sinh_fsm (
  input  logic CLK,
  input  logic RST,
  input  logic start_pulse,
  input  logic sc_ready,
  input  logic last,
  output logic busy,
  output logic done_set,
  output logic cnt_clear,
  output logic cnt_inc,
  output logic sc_start,
  output logic res_we
);

  ntm_sinh_pkg::vec_state_e state_q;
  ntm_sinh_pkg::vec_state_e state_d;

  // Registered launch pulse
  logic sc_start_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ntm_sinh_pkg::IDLE: begin
        // Wait for software start
        if (start_pulse) begin
          state_d = ntm_sinh_pkg::LOAD;
        end
      end
      ntm_sinh_pkg::LOAD: begin
        // Launch is registered, lands in the first wait cycle
        state_d = ntm_sinh_pkg::WAIT_SCALAR;
      end
      ntm_sinh_pkg::WAIT_SCALAR: begin
        if (sc_ready) begin
          // Last element ends the run
          if (last) begin
            state_d = ntm_sinh_pkg::FINISH;
          end else begin
            state_d = ntm_sinh_pkg::LOAD;
          end
        end
      end
      ntm_sinh_pkg::FINISH: begin
        state_d = ntm_sinh_pkg::IDLE;
      end
      default: begin
        state_d = ntm_sinh_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////
  // State and launch registers
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= ntm_sinh_pkg::IDLE;
      sc_start_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      // One pulse per LOAD visit
      sc_start_q <= (state_q == ntm_sinh_pkg::LOAD);
    end
  end

  // Status towards the register block
  assign busy     = (state_q != ntm_sinh_pkg::IDLE);
  assign done_set = (state_q == ntm_sinh_pkg::FINISH);

  // Counter control
  assign cnt_clear = (state_q == ntm_sinh_pkg::IDLE) && start_pulse;
  assign res_we    = (state_q == ntm_sinh_pkg::WAIT_SCALAR) && sc_ready;
  // Index held on the last element
  assign cnt_inc   = res_we && !last;

  assign sc_start = sc_start_q;

  // Scalar completion only while waiting for it
  a_ready_in_wait : assert property (@(posedge CLK) disable iff (RST)
    sc_ready |-> (state_q == ntm_sinh_pkg::WAIT_SCALAR));

endmodule

// ==== hw/ntm_element_counter.sv ====
`timescale 1ns/1ps

module ntm_element_counter (
  input  logic                CLK,
  input  logic                RST,
  input  logic                cnt_clear,
  input  logic                cnt_inc,
  input  ntm_sinh_pkg::size_t size,
  output ntm_sinh_pkg::idx_t  index,
  output logic                last
);

  ntm_sinh_pkg::idx_t  index_q;
  ntm_sinh_pkg::size_t size_m1;

  // Clear wins over increment
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index_q <= '0;
    end else if (cnt_clear) begin
      index_q <= '0;
    end else if (cnt_inc) begin
      index_q <= index_q + 1'b1;
    end
  end

  // Final element position
  assign size_m1 = size - 1'b1;

  assign index = index_q;
  assign last  = ({1'b0, index_q} == size_m1);

  // Controller never steps past the vector end
  a_index_in_range : assert property (@(posedge CLK) disable iff (RST)
    cnt_inc |=> ({1'b0, index_q} < size));

endmodule

// ==== hw/ntm_scalar_sinh.sv ====
`timescale 1ns/1ps

module ntm_scalar_sinh (
  input  logic                CLK,
  input  logic                RST,
  input  logic                sc_start,
  input  ntm_sinh_pkg::elem_t x,
  input  ntm_sinh_pkg::res_t  modulo,
  output logic                sc_ready,
  output ntm_sinh_pkg::res_t  result
);

  ntm_sinh_pkg::sinh_state_e state_q;

  // Operands captured at launch
  ntm_sinh_pkg::elem_t p1_q;
  ntm_sinh_pkg::res_t  mod_q;

  // Partial powers
  ntm_sinh_pkg::elem_t x2_q;
  ntm_sinh_pkg::res_t  p3_q;
  ntm_sinh_pkg::res_t  p5_q;

  // Shared multiplier
  ntm_sinh_pkg::res_t                                   mul_a;
  ntm_sinh_pkg::elem_t                                  mul_b;
  logic [ntm_sinh_pkg::RES_W+ntm_sinh_pkg::ELEM_W-1:0] product;
  ntm_sinh_pkg::res_t                                   prod_q8;

  ntm_sinh_pkg::res_t sum;

  //////////////////////////////
  // Multiplier operand select
  //////////////////////////////

  always_comb begin
    mul_a = '0;
    mul_b = '0;
    case (state_q)
      // x times x
      ntm_sinh_pkg::S_SQ: begin
        mul_a = ntm_sinh_pkg::res_t'(p1_q);
        mul_b = p1_q;
      end
      // x times x2
      ntm_sinh_pkg::S_CUBE: begin
        mul_a = ntm_sinh_pkg::res_t'(p1_q);
        mul_b = x2_q;
      end
      // x3 times x2
      ntm_sinh_pkg::S_FIFTH: begin
        mul_a = p3_q;
        mul_b = x2_q;
      end
      default: begin
        mul_a = '0;
        mul_b = '0;
      end
    endcase
  end

  assign product = mul_a * mul_b;
  // Back to Q8.8 scale, low 32 bits kept
  assign prod_q8 = ntm_sinh_pkg::res_t'(product >> ntm_sinh_pkg::FRAC_BITS);

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= ntm_sinh_pkg::S_IDLE;
      p1_q    <= '0;
      mod_q   <= '0;
      x2_q    <= '0;
      p3_q    <= '0;
      p5_q    <= '0;
    end else begin
      case (state_q)
        ntm_sinh_pkg::S_IDLE: begin
          if (sc_start) begin
            p1_q    <= x;
            mod_q   <= modulo;
            state_q <= ntm_sinh_pkg::S_SQ;
          end
        end
        ntm_sinh_pkg::S_SQ: begin
          // x2 is the multiplier's narrow operand, low 16 bits kept
          x2_q    <= ntm_sinh_pkg::elem_t'(prod_q8);
          state_q <= ntm_sinh_pkg::S_CUBE;
        end
        ntm_sinh_pkg::S_CUBE: begin
          p3_q    <= prod_q8;
          state_q <= ntm_sinh_pkg::S_FIFTH;
        end
        ntm_sinh_pkg::S_FIFTH: begin
          p5_q    <= prod_q8;
          state_q <= ntm_sinh_pkg::S_SUM;
        end
        // Result presented for one cycle
        ntm_sinh_pkg::S_SUM: begin
          state_q <= ntm_sinh_pkg::S_IDLE;
        end
        default: begin
          state_q <= ntm_sinh_pkg::S_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Series sum and reduction
  //////////////////////////////

  // x + x^3/3! + x^5/5!, each term truncated
  assign sum = ntm_sinh_pkg::res_t'(p1_q) + p3_q / ntm_sinh_pkg::DIV_P3 +
               p5_q / ntm_sinh_pkg::DIV_P5;

  // Zero modulus passes the sum through
  assign result = (mod_q == '0) ? sum : (sum % mod_q);

  // Fourth cycle after launch
  assign sc_ready = (state_q == ntm_sinh_pkg::S_SUM);

  // No relaunch while a series is in flight
  a_start_when_idle : assert property (@(posedge CLK) disable iff (RST)
    sc_start |-> (state_q == ntm_sinh_pkg::S_IDLE));

endmodule

// ==== hw/ntm_sinh_accel.sv ====
`timescale 1ns/1ps

module ntm_sinh_accel (
  input  logic                   CLK,
  input  logic                   RST,
  input  ntm_sinh_pkg::apb_req_t apb_req,
  output ntm_sinh_pkg::apb_rsp_t apb_rsp
);

  // Controller handshake
  logic start_pulse;
  logic busy;
  logic done_set;
  logic cnt_clear;
  logic cnt_inc;
  logic last;

  // Scalar handshake
  logic sc_start;
  logic sc_ready;
  logic res_we;

  // Datapath
  ntm_sinh_pkg::idx_t  index;
  ntm_sinh_pkg::size_t size;
  ntm_sinh_pkg::res_t  modulo;
  ntm_sinh_pkg::elem_t elem;
  ntm_sinh_pkg::res_t  result;

  //////////////////////////////
  // Register block
  //////////////////////////////

  ntm_apb_regs regs0 (
    .CLK         (CLK),
    .RST         (RST),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .busy        (busy),
    .done_set    (done_set),
    .index       (index),
    .res_we      (res_we),
    .result      (result),
    .start_pulse (start_pulse),
    .size        (size),
    .modulo      (modulo),
    .elem        (elem)
  );

  //////////////////////////////
  // Vector control
  //////////////////////////////

  ntm_vector_sinh_fsm fsm0 (
    .CLK         (CLK),
    .RST         (RST),
    .start_pulse (start_pulse),
    .sc_ready    (sc_ready),
    .last        (last),
    .busy        (busy),
    .done_set    (done_set),
    .cnt_clear   (cnt_clear),
    .cnt_inc     (cnt_inc),
    .sc_start    (sc_start),
    .res_we      (res_we)
  );

  // Element index
  ntm_element_counter cnt0 (
    .CLK       (CLK),
    .RST       (RST),
    .cnt_clear (cnt_clear),
    .cnt_inc   (cnt_inc),
    .size      (size),
    .index     (index),
    .last      (last)
  );

  // Series evaluation on the selected element
  ntm_scalar_sinh sinh0 (
    .CLK      (CLK),
    .RST      (RST),
    .sc_start (sc_start),
    .x        (elem),
    .modulo   (modulo),
    .sc_ready (sc_ready),
    .result   (result)
  );

endmodule

// ==== test/ntm_tb_clock.sv ====
`timescale 1ns/1ps

module ntm_tb_clock (
  output logic CLK,
  output logic RST
);

  // 40 ns period, starts low
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Reset held for three cycles, dropped on a falling edge
  initial begin
    RST = 1'b1;
    #120;
    RST = 1'b0;
  end

endmodule

// ==== test/ntm_sinh_accel_tb.sv ====
`timescale 1ns/1ps

module ntm_sinh_accel_tb;

  // Input selection per case
  localparam logic [1:0] SEL_KNOWN = 2'd0;
  localparam logic [1:0] SEL_RAMP  = 2'd1;
  localparam logic [1:0] SEL_LCG   = 2'd2;
  localparam int         NUM_CASES = 7;

  // One table row
  typedef struct packed {
    logic [31:0]        size;
    ntm_sinh_pkg::res_t modulo;
    logic [1:0]         sel;
    logic               exp_err;
  } case_t;

  logic                   CLK;
  logic                   RST;
  ntm_sinh_pkg::apb_req_t apb_req;
  ntm_sinh_pkg::apb_rsp_t apb_rsp;

  case_t               cases [NUM_CASES];
  ntm_sinh_pkg::elem_t known_x [5];
  logic [31:0]         lcg_state;
  logic [31:0]         cur_size;
  int                  cycles;
  int                  limit;

  ntm_tb_clock clk0 (
    .CLK (CLK),
    .RST (RST)
  );

  ntm_sinh_accel dut0 (
    .CLK     (CLK),
    .RST     (RST),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("ERR @ %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Series per the spec, wide enough that nothing wraps
  function automatic ntm_sinh_pkg::res_t sinh_ref(input logic [15:0] x, input logic [31:0] m);
    logic [63:0] p1;
    logic [63:0] x2;
    logic [63:0] p3;
    logic [63:0] p5;
    logic [63:0] sum;
    p1  = {48'd0, x};
    x2  = (p1 * p1) >> 8;
    p3  = (p1 * x2) >> 8;
    p5  = (p3 * x2) >> 8;
    sum = p1 + p3 / 6 + p5 / 120;
    if (m == 32'd0) begin
      return sum[31:0];
    end
    return (sum % {32'd0, m});
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Word address inside an element window
  function automatic logic [7:0] elem_addr(input logic [7:0] base, input int i);
    return base + {i[5:0], 2'b00};
  endfunction

  //////////////////////////////
  // APB transfers
  //////////////////////////////

  // Setup, access, then idle, each from a falling edge
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge CLK);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    // Mid-cycle sample, stable until the rising edge
    #1;
    err = apb_rsp.pslverr;
    check_value(apb_rsp.pready, 32'd1, "pready on write");
    @(negedge CLK);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge CLK);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(negedge CLK);
    apb_req.penable = 1'b1;
    #1;
    data = apb_rsp.prdata;
    check_value(apb_rsp.pready, 32'd1, "pready on read");
    @(negedge CLK);
    apb_req = '0;
  endtask

  //////////////////////////////
  // Case table
  //////////////////////////////

  task automatic load_table();
    known_x[0] = 16'h0000;
    known_x[1] = 16'h0100;
    known_x[2] = 16'h0200;
    known_x[3] = 16'h0080;
    known_x[4] = 16'h0300;
    // size, modulus, inputs, expected pslverr
    cases[0] = {32'd5,  32'd0,    SEL_KNOWN, 1'b0};
    cases[1] = {32'd5,  32'd1000, SEL_KNOWN, 1'b0};
    cases[2] = {32'd0,  32'd0,    SEL_KNOWN, 1'b1};
    cases[3] = {32'd17, 32'd0,    SEL_KNOWN, 1'b1};
    cases[4] = {32'd1,  32'd0,    SEL_RAMP,  1'b0};
    cases[5] = {32'd16, 32'd777,  SEL_RAMP,  1'b0};
    cases[6] = {32'd16, 32'd0,    SEL_LCG,   1'b0};
    limit = 0;
    for (int i = 0; i < NUM_CASES; i++) begin
      limit += 6 * int'(cases[i].size) + 40;
    end
    limit = limit * 2;
  endtask

  task automatic run_case(input case_t c);
    logic                err;
    logic [31:0]         rd;
    logic [11:0]         r12;
    int                  n;
    ntm_sinh_pkg::elem_t xin;
    ntm_sinh_pkg::res_t  expv [16];
    apb_write(ntm_sinh_pkg::ADDR_SIZE, c.size, err);
    check_value(err, c.exp_err, "pslverr on SIZE write");
    if (c.exp_err) begin
      // Rejected size leaves the old one
      apb_read(ntm_sinh_pkg::ADDR_SIZE, rd);
      check_value(rd, cur_size, "SIZE after rejected write");
    end else begin
      cur_size = c.size;
      n = int'(c.size);
      apb_write(ntm_sinh_pkg::ADDR_MODULO, c.modulo, err);
      check_value(err, 1'b0, "pslverr on MODULO write");
      apb_read(ntm_sinh_pkg::ADDR_SIZE, rd);
      check_value(rd, c.size, "SIZE readback");
      apb_read(ntm_sinh_pkg::ADDR_MODULO, rd);
      check_value(rd, c.modulo, "MODULO readback");
      for (int i = 0; i < n; i++) begin
        case (c.sel)
          SEL_KNOWN: xin = known_x[i % 5];
          SEL_RAMP: begin
            r12 = i * 183 + 64;
            xin = {4'h0, r12};
          end
          default: begin
            // Kept to 12 bits so x squared fits the Q8.8 word
            lcg_state = lcg_next(lcg_state);
            xin = {4'h0, lcg_state[27:16]};
          end
        endcase
        expv[i] = sinh_ref(xin, c.modulo);
        apb_write(elem_addr(ntm_sinh_pkg::ADDR_IN_BASE, i), {16'd0, xin}, err);
        check_value(err, 1'b0, "pslverr on input write");
      end
      apb_write(ntm_sinh_pkg::ADDR_CTRL, 32'd1, err);
      check_value(err, 1'b0, "pslverr on start");
      // Busy up, old done cleared
      apb_read(ntm_sinh_pkg::ADDR_STATUS, rd);
      check_value(rd, 32'd1, "STATUS after start");
      apb_write(ntm_sinh_pkg::ADDR_MODULO, ~c.modulo, err);
      check_value(err, 1'b1, "pslverr on MODULO write while busy");
      // Poll for done, bounded by the cycle limit
      rd = '0;
      while (rd[ntm_sinh_pkg::STATUS_DONE_BIT] == 1'b0) begin
        apb_read(ntm_sinh_pkg::ADDR_STATUS, rd);
      end
      check_value(rd, 32'd2, "STATUS at completion");
      for (int i = 0; i < n; i++) begin
        apb_read(elem_addr(ntm_sinh_pkg::ADDR_OUT_BASE, i), rd);
        check_value(rd, expv[i], $sformatf("result %0d", i));
      end
      apb_read(ntm_sinh_pkg::ADDR_MODULO, rd);
      check_value(rd, c.modulo, "MODULO after rejected write");
      // Done is sticky
      apb_read(ntm_sinh_pkg::ADDR_STATUS, rd);
      check_value(rd, 32'd2, "STATUS after readback");
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: run still going after %0d cycles", cycles);
      abort_run();
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [31:0] rd;
    apb_req   = '0;
    cycles    = 0;
    cur_size  = '0;
    lcg_state = 32'd70;
    load_table();
    wait (RST == 1'b0);
    // Everything zero out of reset
    apb_read(ntm_sinh_pkg::ADDR_STATUS, rd);
    check_value(rd, 32'd0, "STATUS after reset");
    apb_read(ntm_sinh_pkg::ADDR_SIZE, rd);
    check_value(rd, 32'd0, "SIZE after reset");
    apb_read(ntm_sinh_pkg::ADDR_MODULO, rd);
    check_value(rd, 32'd0, "MODULO after reset");
    apb_read(elem_addr(ntm_sinh_pkg::ADDR_OUT_BASE, 15), rd);
    check_value(rd, 32'd0, "last output after reset");
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(cases[i]);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== build.f ====
hw/ntm_sinh_pkg.sv
hw/ntm_apb_regs.sv
hw/ntm_vector_sinh_fsm.sv
hw/ntm_element_counter.sv
hw/ntm_scalar_sinh.sv
hw/ntm_sinh_accel.sv
test/ntm_tb_clock.sv
test/ntm_sinh_accel_tb.sv

// ==== Bender.yml ====
package:
  name: ntm_sinh_accel

sources:
  # RTL in compile order
  - hw/ntm_sinh_pkg.sv
  - hw/ntm_apb_regs.sv
  - hw/ntm_vector_sinh_fsm.sv
  - hw/ntm_element_counter.sv
  - hw/ntm_scalar_sinh.sv
  - hw/ntm_sinh_accel.sv

  # Simulation only
  - target: test
    files:
      - test/ntm_tb_clock.sv
      - test/ntm_sinh_accel_tb.sv
